//--- hdl/decode_pkg.sv
`default_nettype none

package decode_pkg;

	localparam int XLEN = 32;
	localparam int REG_W = 5;

	// major opcodes, insn[6:0]
	localparam logic [6:0] OPC_LOAD = 7'h03;
	localparam logic [6:0] OPC_MISC_MEM = 7'h0f;
	localparam logic [6:0] OPC_OP_IMM = 7'h13;
	localparam logic [6:0] OPC_AUIPC = 7'h17;
	localparam logic [6:0] OPC_STORE = 7'h23;
	localparam logic [6:0] OPC_OP = 7'h33;
	localparam logic [6:0] OPC_LUI = 7'h37;
	localparam logic [6:0] OPC_BRANCH = 7'h63;
	localparam logic [6:0] OPC_JALR = 7'h67;
	localparam logic [6:0] OPC_JAL = 7'h6f;

	localparam logic [6:0] FUNCT7_BASE = 7'h00;
	localparam logic [6:0] FUNCT7_ALT = 7'h20; // sub, sra, srai
	localparam logic [6:0] FUNCT7_MULDIV = 7'h01;

	localparam logic [REG_W-1:0] LINK_REG_RA = 5'd1;
	localparam logic [REG_W-1:0] LINK_REG_ALT = 5'd5;

	typedef enum logic [5:0]
	{
		II,
		NOP,
		LB,
		LH,
		LW,
		LBU,
		LHU,
		SB,
		SH,
		SW,
		ADDI, SLTI, SLTIU, XORI, ORI, ANDI,
		SLLI, SRLI, SRAI,
		ADDU, SUBU, SLL, SLT, SLTU,
		XOR, SRL, SRA, OR, AND,
		MUL, MULH, MULHSU, MULHU,
		DIV, DIVU, REM, REMU,
		LUI,
		AUIPC,
		BEQ, BNE, BLT, BGE, BLTU, BGEU,
		J,
		JAL,
		JR,
		JALR,
		RET
	} uop_op_t;

endpackage

`default_nettype wire

//--- hdl/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen import decode_pkg::*;
(
	input wire [31:0] insn,
	input wire [XLEN-1:0] pc,
	output logic [XLEN-1:0] imm_i,
	output logic [XLEN-1:0] imm_s,
	output logic [XLEN-1:0] imm_u,
	output logic [XLEN-1:0] pc_plus_u,
	output logic [XLEN-1:0] pc_plus_b,
	output logic [XLEN-1:0] pc_plus_j
);

	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_j;

	assign imm_i = {{(XLEN-12){insn[31]}}, insn[31:20]};
	assign imm_s = {{(XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_u = {insn[31:12], 12'd0};

	// b and j offsets are scattered, bit 0 always zero
	assign imm_b = {{(XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25],
		insn[11:8], 1'b0};
	assign imm_j = {{(XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20],
		insn[30:21], 1'b0};

	assign pc_plus_u = pc + imm_u; // auipc
	assign pc_plus_b = pc + imm_b; // branch target
	assign pc_plus_j = pc + imm_j; // jal target

endmodule

`default_nettype wire

//--- hdl/alu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module alu_decode import decode_pkg::*;
(
	input wire [31:0] insn,
	input wire [XLEN-1:0] imm_i,
	input wire [XLEN-1:0] imm_u,
	input wire [XLEN-1:0] pc_plus_u,
	output logic hit,
	output uop_op_t op,
	output logic dst_valid,
	output logic src_a_valid,
	output logic src_b_valid,
	output logic [XLEN-1:0] imm,
	output logic is_cheap
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [REG_W-1:0] rd;

	assign opcode = insn[6:0];
	assign funct3 = insn[14:12];
	assign funct7 = insn[31:25];
	assign rd = insn[11:7];

	assign hit = opcode inside {OPC_OP_IMM, OPC_OP, OPC_LUI, OPC_AUIPC, OPC_MISC_MEM};

	always_comb
	begin
		op = II;
		dst_valid = 1'b0;
		src_a_valid = 1'b0;
		src_b_valid = 1'b0;
		imm = '0;
		is_cheap = 1'b1;
		case (opcode)
			OPC_OP_IMM:
			begin
				dst_valid = 1'b1;
				src_a_valid = 1'b1;
				imm = imm_i;
				case (funct3)
					3'd0: op = ADDI;
					3'd1: op = (funct7 == FUNCT7_BASE) ? SLLI : II;
					3'd2: op = SLTI;
					3'd3: op = SLTIU;
					3'd4: op = XORI;
					3'd5: op = (funct7 == FUNCT7_BASE) ? SRLI :
						(funct7 == FUNCT7_ALT) ? SRAI : II;
					3'd6: op = ORI;
					default: op = ANDI;
				endcase
			end
			OPC_OP:
			begin
				dst_valid = 1'b1;
				src_a_valid = 1'b1;
				src_b_valid = 1'b1;
				case (funct7)
					FUNCT7_BASE:
					begin
						case (funct3)
							3'd0: op = ADDU;
							3'd1: op = SLL;
							3'd2: op = SLT;
							3'd3: op = SLTU;
							3'd4: op = XOR;
							3'd5: op = SRL;
							3'd6: op = OR;
							default: op = AND;
						endcase
					end
					FUNCT7_ALT:
					begin
						op = (funct3 == 3'd0) ? SUBU : (funct3 == 3'd5) ? SRA : II;
					end
					FUNCT7_MULDIV:
					begin
						is_cheap = 1'b0; // multi-cycle unit
						case (funct3)
							3'd0: op = MUL;
							3'd1: op = MULH;
							3'd2: op = MULHSU;
							3'd3: op = MULHU;
							3'd4: op = DIV;
							3'd5: op = DIVU;
							3'd6: op = REM;
							default: op = REMU;
						endcase
					end
					default: op = II;
				endcase
			end
			OPC_LUI:
			begin
				op = LUI;
				dst_valid = 1'b1;
				imm = imm_u;
			end
			OPC_AUIPC:
			begin
				op = AUIPC;
				dst_valid = 1'b1;
				imm = pc_plus_u; // pc already folded in
			end
			OPC_MISC_MEM: op = NOP; // fence
			default: op = II;
		endcase

		if (op == II)
			is_cheap = 1'b0;
		else if (rd == '0)
		begin
			// result to x0 is thrown away
			op = NOP;
			dst_valid = 1'b0;
			src_a_valid = 1'b0;
			src_b_valid = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/mem_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mem_decode import decode_pkg::*;
(
	input wire [31:0] insn,
	input wire [XLEN-1:0] imm_i,
	input wire [XLEN-1:0] imm_s,
	output logic hit,
	output uop_op_t op,
	output logic is_store,
	output logic dst_valid,
	output logic [XLEN-1:0] imm
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [REG_W-1:0] rd;

	assign opcode = insn[6:0];
	assign funct3 = insn[14:12];
	assign rd = insn[11:7];

	assign hit = (opcode == OPC_LOAD) || (opcode == OPC_STORE);
	assign is_store = (opcode == OPC_STORE);
	assign dst_valid = (opcode == OPC_LOAD) && (rd != '0);
	assign imm = is_store ? imm_s : imm_i;

	always_comb
	begin
		op = II;
		if (opcode == OPC_LOAD)
		begin
			case (funct3)
				3'd0: op = LB;
				3'd1: op = LH;
				3'd2: op = LW;
				3'd4: op = LBU;
				3'd5: op = LHU;
				default: op = II; // ld, lwu are rv64 only
			endcase
		end
		else if (opcode == OPC_STORE)
		begin
			case (funct3)
				3'd0: op = SB;
				3'd1: op = SH;
				3'd2: op = SW;
				default: op = II;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/ctrl_flow_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_flow_decode import decode_pkg::*;
(
	input wire [31:0] insn,
	input wire insn_pred,
	input wire [XLEN-1:0] pc_plus_b,
	input wire [XLEN-1:0] pc_plus_j,
	input wire [XLEN-1:0] imm_i,
	output logic hit,
	output uop_op_t op,
	output logic dst_valid,
	output logic src_a_valid,
	output logic src_b_valid,
	output logic [XLEN-1:0] imm,
	output logic br_pred,
	output logic is_cheap
);

	logic [6:0] opcode;
	logic [REG_W-1:0] rd;
	logic [REG_W-1:0] rs1;
	logic rs1_is_link;

	assign opcode = insn[6:0];
	assign rd = insn[11:7];
	assign rs1 = insn[19:15];
	assign rs1_is_link = (rs1 == LINK_REG_RA) || (rs1 == LINK_REG_ALT);

	assign hit = opcode inside {OPC_BRANCH, OPC_JAL, OPC_JALR};

	always_comb
	begin
		op = II;
		dst_valid = 1'b0;
		src_a_valid = 1'b0;
		src_b_valid = 1'b0;
		imm = '0;
		br_pred = 1'b1; // jumps are always taken
		is_cheap = 1'b1;
		case (opcode)
			OPC_BRANCH:
			begin
				src_a_valid = 1'b1;
				src_b_valid = 1'b1;
				imm = pc_plus_b;
				br_pred = insn_pred;
				case (insn[14:12])
					3'd0: op = BEQ;
					3'd1: op = BNE;
					3'd4: op = BLT;
					3'd5: op = BGE;
					3'd6: op = BLTU;
					3'd7: op = BGEU;
					default: op = II;
				endcase
			end
			OPC_JAL:
			begin
				imm = pc_plus_j;
				dst_valid = (rd != '0);
				op = (rd == '0) ? J : JAL;
				is_cheap = (rd != '0);
			end
			OPC_JALR:
			begin
				src_a_valid = 1'b1;
				imm = imm_i;
				dst_valid = (rd != '0);
				if (rd != '0)
					op = JALR;
				else
					op = rs1_is_link ? RET : JR; // ret pops the ras
			end
			default:
			begin
				br_pred = 1'b0;
				is_cheap = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/uop_reg.sv
`timescale 1ns/1ps
`default_nettype none

module uop_reg import decode_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire insn_valid,
	input wire [31:0] insn,
	input wire [XLEN-1:0] pc,
	input wire [XLEN-1:0] insn_pred_target,
	input wire alu_hit,
	input var uop_op_t alu_op,
	input wire alu_dst_valid,
	input wire alu_src_a_valid,
	input wire alu_src_b_valid,
	input wire [XLEN-1:0] alu_imm,
	input wire alu_is_cheap,
	input wire mem_hit,
	input var uop_op_t mem_op,
	input wire mem_is_store,
	input wire mem_dst_valid,
	input wire [XLEN-1:0] mem_imm,
	input wire cf_hit,
	input var uop_op_t cf_op,
	input wire cf_dst_valid,
	input wire cf_src_a_valid,
	input wire cf_src_b_valid,
	input wire [XLEN-1:0] cf_imm,
	input wire cf_br_pred,
	input wire cf_is_cheap,
	output logic uop_valid,
	output uop_op_t uop_op,
	output logic [REG_W-1:0] uop_dst,
	output logic uop_dst_valid,
	output logic [REG_W-1:0] uop_src_a,
	output logic uop_src_a_valid,
	output logic [REG_W-1:0] uop_src_b,
	output logic uop_src_b_valid,
	output logic [XLEN-1:0] uop_imm,
	output logic [XLEN-1:0] uop_pc,
	output logic [XLEN-1:0] uop_jmp_target,
	output logic uop_is_mem,
	output logic uop_is_store,
	output logic uop_is_br,
	output logic uop_is_int,
	output logic uop_is_cheap_int,
	output logic uop_br_pred
);

	uop_op_t n_op;
	logic n_dst_valid;
	logic n_src_a_valid;
	logic n_src_b_valid;
	logic [XLEN-1:0] n_imm;
	logic n_is_cheap;
	logic n_br_pred;
	logic [XLEN-1:0] n_jmp_target;

	always_comb
	begin
		n_op = II;
		n_dst_valid = 1'b0;
		n_src_a_valid = 1'b0;
		n_src_b_valid = 1'b0;
		n_imm = '0;
		n_is_cheap = 1'b0;
		n_br_pred = 1'b0;
		n_jmp_target = '0;
		if (alu_hit)
		begin
			n_op = alu_op;
			n_dst_valid = alu_dst_valid;
			n_src_a_valid = alu_src_a_valid;
			n_src_b_valid = alu_src_b_valid;
			n_imm = alu_imm;
			n_is_cheap = alu_is_cheap;
		end
		else if (mem_hit)
		begin
			n_op = mem_op;
			n_dst_valid = mem_dst_valid;
			n_src_a_valid = 1'b1; // base address
			n_src_b_valid = mem_is_store; // store data
			n_imm = mem_imm;
		end
		else if (cf_hit)
		begin
			n_op = cf_op;
			n_dst_valid = cf_dst_valid;
			n_src_a_valid = cf_src_a_valid;
			n_src_b_valid = cf_src_b_valid;
			n_imm = cf_imm;
			n_is_cheap = cf_is_cheap;
			n_br_pred = cf_br_pred;
			if (cf_op inside {JR, JALR, RET})
				n_jmp_target = insn_pred_target;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			uop_valid <= 1'b0;
			uop_op <= II;
			uop_dst <= '0;
			uop_dst_valid <= 1'b0;
			uop_src_a <= '0;
			uop_src_a_valid <= 1'b0;
			uop_src_b <= '0;
			uop_src_b_valid <= 1'b0;
			uop_imm <= '0;
			uop_pc <= '0;
			uop_jmp_target <= '0;
			uop_is_mem <= 1'b0;
			uop_is_store <= 1'b0;
			uop_is_br <= 1'b0;
			uop_is_int <= 1'b0;
			uop_is_cheap_int <= 1'b0;
			uop_br_pred <= 1'b0;
		end
		else
		begin
			uop_valid <= insn_valid;
			if (insn_valid)
			begin
				uop_op <= n_op;
				uop_dst <= insn[11:7];
				uop_dst_valid <= n_dst_valid;
				uop_src_a <= insn[19:15];
				uop_src_a_valid <= n_src_a_valid;
				uop_src_b <= insn[24:20];
				uop_src_b_valid <= n_src_b_valid;
				uop_imm <= n_imm;
				uop_pc <= pc;
				uop_jmp_target <= n_jmp_target;
				uop_is_mem <= mem_hit;
				uop_is_store <= mem_hit && mem_is_store;
				uop_is_br <= cf_hit;
				uop_is_int <= alu_hit || cf_hit;
				uop_is_cheap_int <= n_is_cheap;
				uop_br_pred <= n_br_pred;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top import decode_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire insn_valid,
	input wire [31:0] insn,
	input wire [XLEN-1:0] pc,
	input wire insn_pred,
	input wire [XLEN-1:0] insn_pred_target,
	output logic uop_valid,
	output uop_op_t uop_op,
	output logic [REG_W-1:0] uop_dst,
	output logic uop_dst_valid,
	output logic [REG_W-1:0] uop_src_a,
	output logic uop_src_a_valid,
	output logic [REG_W-1:0] uop_src_b,
	output logic uop_src_b_valid,
	output logic [XLEN-1:0] uop_imm,
	output logic [XLEN-1:0] uop_pc,
	output logic [XLEN-1:0] uop_jmp_target,
	output logic uop_is_mem,
	output logic uop_is_store,
	output logic uop_is_br,
	output logic uop_is_int,
	output logic uop_is_cheap_int,
	output logic uop_br_pred
);

	logic [XLEN-1:0] imm_i, imm_s, imm_u;
	logic [XLEN-1:0] pc_plus_u, pc_plus_b, pc_plus_j;

	logic alu_hit, alu_dst_valid, alu_src_a_valid, alu_src_b_valid, alu_is_cheap;
	uop_op_t alu_op;
	logic [XLEN-1:0] alu_imm;

	logic mem_hit, mem_is_store, mem_dst_valid;
	uop_op_t mem_op;
	logic [XLEN-1:0] mem_imm;

	logic cf_hit, cf_dst_valid, cf_src_a_valid, cf_src_b_valid, cf_br_pred, cf_is_cheap;
	uop_op_t cf_op;
	logic [XLEN-1:0] cf_imm;

	imm_gen u_imm_gen (.insn(insn), .pc(pc), .imm_i(imm_i), .imm_s(imm_s), .imm_u(imm_u),
		.pc_plus_u(pc_plus_u), .pc_plus_b(pc_plus_b), .pc_plus_j(pc_plus_j));

	alu_decode u_alu (.insn(insn), .imm_i(imm_i), .imm_u(imm_u), .pc_plus_u(pc_plus_u),
		.hit(alu_hit), .op(alu_op), .dst_valid(alu_dst_valid),
		.src_a_valid(alu_src_a_valid), .src_b_valid(alu_src_b_valid),
		.imm(alu_imm), .is_cheap(alu_is_cheap));

	mem_decode u_mem (.insn(insn), .imm_i(imm_i), .imm_s(imm_s), .hit(mem_hit), .op(mem_op),
		.is_store(mem_is_store), .dst_valid(mem_dst_valid), .imm(mem_imm));

	ctrl_flow_decode u_cf (.insn(insn), .insn_pred(insn_pred), .pc_plus_b(pc_plus_b),
		.pc_plus_j(pc_plus_j), .imm_i(imm_i), .hit(cf_hit), .op(cf_op),
		.dst_valid(cf_dst_valid), .src_a_valid(cf_src_a_valid),
		.src_b_valid(cf_src_b_valid), .imm(cf_imm), .br_pred(cf_br_pred),
		.is_cheap(cf_is_cheap));

	uop_reg u_uop_reg (.clk(clk), .rst_n(rst_n), .insn_valid(insn_valid), .insn(insn),
		.pc(pc), .insn_pred_target(insn_pred_target),
		.alu_hit(alu_hit), .alu_op(alu_op), .alu_dst_valid(alu_dst_valid),
		.alu_src_a_valid(alu_src_a_valid), .alu_src_b_valid(alu_src_b_valid),
		.alu_imm(alu_imm), .alu_is_cheap(alu_is_cheap),
		.mem_hit(mem_hit), .mem_op(mem_op), .mem_is_store(mem_is_store),
		.mem_dst_valid(mem_dst_valid), .mem_imm(mem_imm),
		.cf_hit(cf_hit), .cf_op(cf_op), .cf_dst_valid(cf_dst_valid),
		.cf_src_a_valid(cf_src_a_valid), .cf_src_b_valid(cf_src_b_valid),
		.cf_imm(cf_imm), .cf_br_pred(cf_br_pred), .cf_is_cheap(cf_is_cheap),
		.uop_valid(uop_valid), .uop_op(uop_op), .uop_dst(uop_dst),
		.uop_dst_valid(uop_dst_valid), .uop_src_a(uop_src_a),
		.uop_src_a_valid(uop_src_a_valid), .uop_src_b(uop_src_b),
		.uop_src_b_valid(uop_src_b_valid), .uop_imm(uop_imm), .uop_pc(uop_pc),
		.uop_jmp_target(uop_jmp_target), .uop_is_mem(uop_is_mem),
		.uop_is_store(uop_is_store), .uop_is_br(uop_is_br), .uop_is_int(uop_is_int),
		.uop_is_cheap_int(uop_is_cheap_int), .uop_br_pred(uop_br_pred));

endmodule

`default_nettype wire

//--- bench/decode_checker.sv
`timescale 1ns/1ps
`default_nettype none

module decode_checker import decode_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire exp_valid,
	input wire [7:0] exp_idx,
	input var uop_op_t exp_op,
	input wire [8:0] exp_flags,
	input wire [XLEN-1:0] exp_imm,
	input wire [8*12-1:0] exp_name,
	input wire [31:0] insn,
	input wire [XLEN-1:0] pc,
	input wire [XLEN-1:0] insn_pred_target,
	input wire uop_valid,
	input var uop_op_t uop_op,
	input wire [REG_W-1:0] uop_dst,
	input wire uop_dst_valid,
	input wire [REG_W-1:0] uop_src_a,
	input wire uop_src_a_valid,
	input wire [REG_W-1:0] uop_src_b,
	input wire uop_src_b_valid,
	input wire [XLEN-1:0] uop_imm,
	input wire [XLEN-1:0] uop_pc,
	input wire [XLEN-1:0] uop_jmp_target,
	input wire uop_is_mem,
	input wire uop_is_store,
	input wire uop_is_br,
	input wire uop_is_int,
	input wire uop_is_cheap_int,
	input wire uop_br_pred,
	output int pass_count,
	output int error_count,
	output int rows_seen
);

	logic d_valid;
	logic [7:0] d_idx;
	uop_op_t d_op;
	logic [8:0] d_flags;
	logic [XLEN-1:0] d_imm;
	logic [8*12-1:0] d_name;
	logic [31:0] d_insn;
	logic [XLEN-1:0] d_pc;
	logic [XLEN-1:0] d_target;
	string bad;

	task automatic note_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			bad = {bad, " ", name};
	endtask

	initial
	begin
		pass_count = 0;
		error_count = 0;
		rows_seen = 0;
	end

	// lines the expected row up with the registered micro-op
	always @(posedge clk)
	begin
		if (!rst_n)
			d_valid <= 1'b0;
		else
			d_valid <= exp_valid;
		d_idx <= exp_idx;
		d_op <= exp_op;
		d_flags <= exp_flags;
		d_imm <= exp_imm;
		d_name <= exp_name;
		d_insn <= insn;
		d_pc <= pc;
		d_target <= insn_pred_target;
	end

	always @(negedge clk)
	begin
		if (d_valid && uop_valid !== 1'b1)
		begin
			error_count++;
			rows_seen++;
			$display("row %0d (%s) gave no micro-op one cycle after it was driven",
				d_idx, d_name);
		end
		else if (!d_valid && uop_valid !== 1'b0)
		begin
			error_count++;
			$display("micro-op valid at %0t with no instruction driven before it", $time);
		end
		else if (d_valid)
		begin
			rows_seen++;
			bad = "";
			note_field("op", uop_op, d_op);
			note_field("dst_valid", uop_dst_valid, d_flags[8]);
			note_field("src_a_valid", uop_src_a_valid, d_flags[7]);
			note_field("src_b_valid", uop_src_b_valid, d_flags[6]);
			note_field("is_mem", uop_is_mem, d_flags[5]);
			note_field("is_store", uop_is_store, d_flags[4]);
			note_field("is_br", uop_is_br, d_flags[3]);
			note_field("is_int", uop_is_int, d_flags[2]);
			note_field("is_cheap_int", uop_is_cheap_int, d_flags[1]);
			note_field("br_pred", uop_br_pred, d_flags[0]);
			note_field("imm", uop_imm, d_imm);
			note_field("dst", uop_dst, d_insn[11:7]);
			note_field("src_a", uop_src_a, d_insn[19:15]);
			note_field("src_b", uop_src_b, d_insn[24:20]);
			note_field("pc", uop_pc, d_pc);
			if (d_op == JR || d_op == JALR || d_op == RET)
				note_field("jmp_target", uop_jmp_target, d_target); // jalr family only
			else
				note_field("jmp_target", uop_jmp_target, '0);
			if (bad == "")
			begin
				pass_count++;
				$display("PASS row %0d %s", d_idx, d_name);
			end
			else
			begin
				error_count++;
				$display("[ERROR] %0t: %s: wrong%s", $time, d_name, bad);
			end
		end
	end

endmodule

`default_nettype wire

//--- bench/tb_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode import decode_pkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam int MAX_ROWS = 48;

	logic clk;
	logic rst_n;
	logic insn_valid;
	logic [31:0] insn;
	logic [XLEN-1:0] pc;
	logic insn_pred;
	logic [XLEN-1:0] insn_pred_target;

	logic uop_valid;
	uop_op_t uop_op;
	logic [REG_W-1:0] uop_dst;
	logic uop_dst_valid;
	logic [REG_W-1:0] uop_src_a;
	logic uop_src_a_valid;
	logic [REG_W-1:0] uop_src_b;
	logic uop_src_b_valid;
	logic [XLEN-1:0] uop_imm;
	logic [XLEN-1:0] uop_pc;
	logic [XLEN-1:0] uop_jmp_target;
	logic uop_is_mem;
	logic uop_is_store;
	logic uop_is_br;
	logic uop_is_int;
	logic uop_is_cheap_int;
	logic uop_br_pred;

	logic exp_valid;
	logic [7:0] exp_idx;
	uop_op_t exp_op;
	logic [8:0] exp_flags;
	logic [XLEN-1:0] exp_imm;
	logic [8*12-1:0] exp_name;
	int pass_count;
	int error_count;
	int rows_seen;

	logic [31:0] row_insn [0:MAX_ROWS-1];
	logic [XLEN-1:0] row_pc [0:MAX_ROWS-1];
	logic row_pred [0:MAX_ROWS-1];
	uop_op_t row_op [0:MAX_ROWS-1];
	logic [8:0] row_flags [0:MAX_ROWS-1];
	logic [XLEN-1:0] row_imm [0:MAX_ROWS-1];
	logic [8*12-1:0] row_name [0:MAX_ROWS-1];
	int n_rows;
	logic [XLEN-1:0] cur_pc;
	logic cur_pred;
	integer seed;

	decode_top dut (.*);

	decode_checker u_checker (.*);

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
		input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	task automatic add_row(input logic [31:0] word, input uop_op_t op, input logic [8:0] flags,
		input logic [XLEN-1:0] imm, input logic [8*12-1:0] name);
		row_insn[n_rows] = word;
		row_pc[n_rows] = cur_pc;
		row_pred[n_rows] = cur_pred;
		row_op[n_rows] = op;
		row_flags[n_rows] = flags;
		row_imm[n_rows] = imm;
		row_name[n_rows] = name;
		n_rows++;
	endtask

	// flags are dst, src_a, src_b valids then mem, store, br, int, cheap, pred
	task automatic build_table();
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		uop_op_t op;
		cur_pc = 32'h0000_1000;
		cur_pred = 1'b0;
		add_row(i_type(-12'd5, 2, 0, 3, OPC_OP_IMM), ADDI, 9'b110_000_110, 32'hfffffffb, "addi");
		add_row(i_type(12'h403, 1, 5, 4, OPC_OP_IMM), SRAI, 9'b110_000_110, 32'h403, "srai");
		add_row(i_type(12'h7ff, 6, 7, 9, OPC_OP_IMM), ANDI, 9'b110_000_110, 32'h7ff, "andi");
		add_row(i_type(12'd0, 0, 0, 0, OPC_OP_IMM), NOP, 9'b000_000_110, 0, "nop_x0");
		add_row(r_type(7'h00, 7, 6, 0, 5, OPC_OP), ADDU, 9'b111_000_110, 0, "add");
		add_row(r_type(7'h20, 10, 9, 0, 8, OPC_OP), SUBU, 9'b111_000_110, 0, "sub");
		add_row(r_type(7'h20, 13, 12, 5, 11, OPC_OP), SRA, 9'b111_000_110, 0, "sra");
		add_row(r_type(7'h00, 3, 2, 3, 1, OPC_OP), SLTU, 9'b111_000_110, 0, "sltu");
		add_row(r_type(7'h01, 16, 15, 0, 14, OPC_OP), MUL, 9'b111_000_100, 0, "mul");
		add_row(r_type(7'h01, 19, 18, 5, 17, OPC_OP), DIVU, 9'b111_000_100, 0, "divu");
		add_row(r_type(7'h01, 22, 21, 7, 20, OPC_OP), REMU, 9'b111_000_100, 0, "remu");
		add_row(r_type(7'h00, 2, 1, 4, 0, OPC_OP), NOP, 9'b000_000_110, 0, "xor_x0");
		add_row(u_type(20'h12345, 20, OPC_LUI), LUI, 9'b100_000_110, 32'h12345000, "lui");
		add_row(u_type(20'h80000, 21, OPC_AUIPC), AUIPC, 9'b100_000_110, 32'h80001000, "auipc");
		add_row(32'h0ff0000f, NOP, 9'b000_000_110, 0, "fence");
		add_row(i_type(-12'd4, 2, 2, 6, OPC_LOAD), LW, 9'b110_100_000, 32'hfffffffc, "lw");
		add_row(i_type(12'h7ff, 3, 4, 7, OPC_LOAD), LBU, 9'b110_100_000, 32'h7ff, "lbu");
		add_row(i_type(12'd0, 2, 3, 9, OPC_LOAD), II, 9'b110_100_000, 0, "ld");
		add_row(i_type(12'd8, 2, 6, 9, OPC_LOAD), II, 9'b110_100_000, 8, "lwu");
		add_row(s_type(-12'd8, 5, 2, 2), SW, 9'b011_110_000, 32'hfffffff8, "sw");
		add_row(s_type(12'h123, 5, 4, 0), SB, 9'b011_110_000, 32'h123, "sb");
		add_row(s_type(12'd4, 5, 4, 4), II, 9'b011_110_000, 4, "st_f3_4");
		cur_pred = 1'b1;
		add_row(b_type(13'd16, 2, 1, 0), BEQ, 9'b011_001_111, 32'h1010, "beq");
		cur_pc = 32'h0000_2000;
		cur_pred = 1'b0;
		add_row(b_type(-13'd8, 4, 3, 1), BNE, 9'b011_001_110, 32'h1ff8, "bne_neg");
		cur_pc = 32'h0000_3000;
		cur_pred = 1'b1;
		add_row(b_type(-13'd4096, 6, 5, 6), BLTU, 9'b011_001_111, 32'h2000, "bltu_min");
		cur_pc = 32'h0000_1000;
		cur_pred = 1'b0; // jumps must still predict taken
		add_row(j_type(21'd2048, 0), J, 9'b000_001_101, 32'h1800, "j");
		add_row(j_type(-21'd16, 1), JAL, 9'b100_001_111, 32'h0ff0, "jal");
		add_row(i_type(12'd0, 1, 0, 0, OPC_JALR), RET, 9'b010_001_111, 0, "ret_x1");
		add_row(i_type(12'd0, 5, 0, 0, OPC_JALR), RET, 9'b010_001_111, 0, "ret_x5");
		add_row(i_type(12'd4, 6, 0, 0, OPC_JALR), JR, 9'b010_001_111, 4, "jr");
		add_row(i_type(12'd8, 10, 0, 1, OPC_JALR), JALR, 9'b110_001_111, 8, "jalr");
		add_row(32'h0000007f, II, 9'b000_000_000, 0, "unknown");
		add_row(32'h00000073, II, 9'b000_000_000, 0, "ecall");
		for (int k = 0; k < 3; k++)
		begin
			rd = $random(seed);
			rs1 = $random(seed);
			rs2 = $random(seed);
			if (rd == '0)
				rd = 5'd31;
			f3 = (k == 0) ? 3'd4 : (k == 1) ? 3'd6 : 3'd7;
			op = (k == 0) ? XOR : (k == 1) ? OR : AND;
			add_row(r_type(7'h00, rs2, rs1, f3, rd, OPC_OP), op, 9'b111_000_110, 0, "rand_op");
		end
	endtask

	task automatic drive_row(input int i);
		insn_valid = 1'b1;
		insn = row_insn[i];
		pc = row_pc[i];
		insn_pred = row_pred[i];
		insn_pred_target = 32'h8000_0000 | (i << 4); // distinct per row
		exp_valid = 1'b1;
		exp_idx = i;
		exp_op = row_op[i];
		exp_flags = row_flags[i];
		exp_imm = row_imm[i];
		exp_name = row_name[i];
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#1;
		#((n_rows + 20) * CLK_PERIOD);
		$display("timeout: only %0d of %0d micro-ops arrived", rows_seen, n_rows);
		$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		rst_n = 1'b0;
		insn_valid = 1'b0;
		insn = '0;
		pc = '0;
		insn_pred = 1'b0;
		insn_pred_target = '0;
		exp_valid = 1'b0;
		exp_idx = '0;
		exp_op = II;
		exp_flags = '0;
		exp_imm = '0;
		exp_name = '0;
		seed = 58911;
		n_rows = 0;
		build_table();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < n_rows; i++)
		begin
			@(negedge clk);
			if (i == n_rows / 2)
			begin
				insn_valid = 1'b0; // idle slot mid-stream
				exp_valid = 1'b0;
				@(negedge clk);
			end
			drive_row(i);
		end
		@(negedge clk);
		insn_valid = 1'b0;
		exp_valid = 1'b0;
		wait (rows_seen == n_rows);
		repeat (3) @(negedge clk);
		$display("done: %0d passed, %0d errors", pass_count, error_count);
		if (error_count == 0 && pass_count == n_rows)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
hdl/decode_pkg.sv
hdl/imm_gen.sv
hdl/alu_decode.sv
hdl/mem_decode.sv
hdl/ctrl_flow_decode.sv
hdl/uop_reg.sv
hdl/decode_top.sv
bench/decode_checker.sv
bench/tb_decode.sv
